/* rtl/bpu_pkg.sv */
`default_nettype none

package bpu_pkg;

    // widths and table sizes
    localparam int xlen        = 32;
    localparam int bim_entries = 512;
    localparam int bim_idx_w   = 9;   // pc[9:1]
    localparam int btb_entries = 256;
    localparam int btb_idx_w   = 8;   // pc[9:2]
    localparam int btb_tag_w   = 22;  // pc[31:10]
    localparam int ras_depth   = 64;
    localparam int ras_ptr_w   = 7;   // counts 0..64

    // rv32 opcodes for control flow
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;

    // link registers
    localparam logic [4:0] reg_ra = 5'd1;
    localparam logic [4:0] reg_t0 = 5'd5;

    // 2-bit counter start value
    localparam logic [1:0] ctr_weak_nt = 2'b01;

    // one fetched word, read as b-type or j-type
    typedef union packed {
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;   // rd field in i/j formats
            logic       imm11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } inst_u;

endpackage

`default_nettype wire

/* rtl/inst_predecode.sv */
`timescale 1ns/10ps
`default_nettype none

module inst_predecode import bpu_pkg::*; (
    input  inst_u             inst_i,
    output logic              is_branch_o,
    output logic              is_jal_o,
    output logic              is_jalr_o,
    output logic              is_ret_o,
    output logic [xlen-1:0]   b_off_o,
    output logic [xlen-1:0]   j_off_o
);

    logic       link_rs1;   // rs1 is ra or t0
    logic       imm_zero;
    logic [4:0] rd;

    assign is_branch_o = (inst_i.b.opcode == op_branch);
    assign is_jal_o    = (inst_i.j.opcode == op_jal);
    assign is_jalr_o   = (inst_i.j.opcode == op_jalr);

    // i-type imm sits over imm12, imm10_5 and rs2 of the b view
    assign imm_zero = ({inst_i.b.imm12, inst_i.b.imm10_5, inst_i.b.rs2} == 12'd0);
    assign link_rs1 = (inst_i.b.rs1 == reg_ra) || (inst_i.b.rs1 == reg_t0);
    assign rd       = inst_i.j.rd;

    // jalr x0, 0(ra|t0)
    assign is_ret_o = is_jalr_o && (rd == 5'd0) && link_rs1 && imm_zero;

    // b-type offset, +-4 KiB
    assign b_off_o = {{19{inst_i.b.imm12}},
                      inst_i.b.imm12,
                      inst_i.b.imm11,
                      inst_i.b.imm10_5,
                      inst_i.b.imm4_1,
                      1'b0};

    // j-type offset, +-1 MiB
    assign j_off_o = {{11{inst_i.j.imm20}},
                      inst_i.j.imm20,
                      inst_i.j.imm19_12,
                      inst_i.j.imm11,
                      inst_i.j.imm10_1,
                      1'b0};

endmodule

`default_nettype wire

/* rtl/bimodal_table.sv */
`timescale 1ns/10ps
`default_nettype none

module bimodal_table import bpu_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [xlen-1:0]   rd_pc_i,
    input  logic              upd_valid_i,
    input  logic [xlen-1:0]   upd_pc_i,
    input  logic              upd_taken_i,
    output logic              taken_o
);

    logic [1:0]           ctr_q [bim_entries];
    logic [bim_idx_w-1:0] rd_idx;
    logic [bim_idx_w-1:0] upd_idx;
    logic [1:0]           upd_cur;
    logic [1:0]           upd_nxt;

    // halfword granule so compressed code would still index sensibly
    assign rd_idx  = rd_pc_i[bim_idx_w:1];
    assign upd_idx = upd_pc_i[bim_idx_w:1];

    assign taken_o = ctr_q[rd_idx][1];  // msb is the direction

    assign upd_cur = ctr_q[upd_idx];

    // saturating step
    always_comb begin
        upd_nxt = upd_cur;
        if (upd_taken_i) begin
            if (upd_cur != 2'b11) begin
                upd_nxt = upd_cur + 2'b01;
            end
        end else begin
            if (upd_cur != 2'b00) begin
                upd_nxt = upd_cur - 2'b01;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < bim_entries; i++) begin
                ctr_q[i] <= ctr_weak_nt;
            end
        end else if (upd_valid_i) begin
            ctr_q[upd_idx] <= upd_nxt;
        end
    end

endmodule

`default_nettype wire

/* rtl/branch_target_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

module branch_target_buffer import bpu_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [xlen-1:0]   rd_pc_i,
    input  logic              wr_valid_i,
    input  logic [xlen-1:0]   wr_pc_i,
    input  logic [xlen-1:0]   wr_target_i,
    output logic              hit_o,
    output logic [xlen-1:0]   target_o
);

    logic                 valid_q  [btb_entries];
    logic [btb_tag_w-1:0] tag_q    [btb_entries];
    logic [xlen-1:0]      target_q [btb_entries];

    logic [btb_idx_w-1:0] rd_idx;
    logic [btb_tag_w-1:0] rd_tag;
    logic [btb_idx_w-1:0] wr_idx;
    logic [btb_tag_w-1:0] wr_tag;

    // word index below, everything above bit 9 is tag
    assign rd_idx = rd_pc_i[btb_idx_w+1:2];
    assign rd_tag = rd_pc_i[xlen-1:xlen-btb_tag_w];
    assign wr_idx = wr_pc_i[btb_idx_w+1:2];
    assign wr_tag = wr_pc_i[xlen-1:xlen-btb_tag_w];

    // combinational lookup
    assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign target_o = target_q[rd_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < btb_entries; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (wr_valid_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // direct mapped, a write simply evicts the old entry
    always_ff @(posedge clk) begin
        if (wr_valid_i) begin
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= wr_target_i;
        end
    end

endmodule

`default_nettype wire

/* rtl/return_addr_stack.sv */
`timescale 1ns/10ps
`default_nettype none

module return_addr_stack import bpu_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              push_i,
    input  logic [xlen-1:0]   push_addr_i,
    input  logic              pop_i,
    output logic              nonempty_o,
    output logic [xlen-1:0]   top_o
);

    logic [xlen-1:0]      stack_q [ras_depth];
    logic [ras_ptr_w-1:0] ptr_q;      // next free slot, 0 = empty
    logic [ras_ptr_w-1:0] ptr_pop;
    logic [ras_ptr_w-1:0] ptr_nxt;
    logic [ras_ptr_w-2:0] top_idx;
    logic                 pop_ok;
    logic                 push_ok;

    assign nonempty_o = (ptr_q != '0);

    // wraps to 63 when full, which is the right slot
    assign top_idx = ptr_q[ras_ptr_w-2:0] - 1'b1;
    assign top_o   = stack_q[top_idx];

    // pop first, then push lands on the post-pop pointer
    assign pop_ok  = pop_i && nonempty_o;
    assign ptr_pop = pop_ok ? ptr_q - 1'b1 : ptr_q;
    assign push_ok = push_i && (ptr_pop != ras_ptr_w'(ras_depth));  // full drops push
    assign ptr_nxt = push_ok ? ptr_pop + 1'b1 : ptr_pop;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ptr_q <= '0;
        end else begin
            ptr_q <= ptr_nxt;
        end
    end

    // entries above the pointer are don't care
    always_ff @(posedge clk) begin
        if (push_ok) begin
            stack_q[ptr_pop[ras_ptr_w-2:0]] <= push_addr_i;
        end
    end

endmodule

`default_nettype wire

/* rtl/bpu_top.sv */
`timescale 1ns/10ps
`default_nettype none

module bpu_top import bpu_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    // fetch
    input  logic [xlen-1:0]   if_pc_i,
    input  logic [xlen-1:0]   if_inst_i,
    // decode call
    input  logic              id_push_valid_i,
    input  logic [xlen-1:0]   id_push_addr_i,
    input  logic              id_stall_i,
    // execute resolution
    input  logic              ex_valid_i,
    input  logic              ex_taken_i,
    input  logic [xlen-1:0]   ex_pc_i,
    input  logic [xlen-1:0]   ex_inst_i,
    input  logic [xlen-1:0]   ex_target_i,
    input  logic              ex_stall_i,
    // prediction
    output logic              branch_o,
    output logic              pred_taken_o,
    output logic [xlen-1:0]   pred_pc_o
);

    logic            if_is_branch;
    logic            if_is_jal;
    logic            if_is_jalr;
    logic            if_is_ret;
    logic [xlen-1:0] if_b_off;
    logic [xlen-1:0] if_j_off;
    logic            ex_is_ret;
    logic            bim_taken;
    logic            btb_hit;
    logic [xlen-1:0] btb_target;
    logic            ras_nonempty;
    logic [xlen-1:0] ras_top;
    logic            ras_push;
    logic            ras_pop;
    logic [xlen-1:0] pc_plus4;

    inst_predecode if_dec (
        .inst_i      (if_inst_i),
        .is_branch_o (if_is_branch),
        .is_jal_o    (if_is_jal),
        .is_jalr_o   (if_is_jalr),
        .is_ret_o    (if_is_ret),
        .b_off_o     (if_b_off),
        .j_off_o     (if_j_off)
    );

    // only the return test matters on the execute side
    inst_predecode ex_dec (
        .inst_i      (ex_inst_i),
        .is_branch_o (),
        .is_jal_o    (),
        .is_jalr_o   (),
        .is_ret_o    (ex_is_ret),
        .b_off_o     (),
        .j_off_o     ()
    );

    bimodal_table bim0 (
        .clk         (clk),
        .rst         (rst),
        .rd_pc_i     (if_pc_i),
        .upd_valid_i (ex_valid_i),
        .upd_pc_i    (ex_pc_i),
        .upd_taken_i (ex_taken_i),
        .taken_o     (bim_taken)
    );

    branch_target_buffer btb0 (
        .clk         (clk),
        .rst         (rst),
        .rd_pc_i     (if_pc_i),
        .wr_valid_i  (ex_valid_i && ex_taken_i),  // only taken ones get a target
        .wr_pc_i     (ex_pc_i),
        .wr_target_i (ex_target_i),
        .hit_o       (btb_hit),
        .target_o    (btb_target)
    );

    // stalls freeze the stack, table training keeps going
    assign ras_push = id_push_valid_i && !id_stall_i && !ex_stall_i;
    assign ras_pop  = ex_valid_i && ex_taken_i && ex_is_ret && !ex_stall_i;

    return_addr_stack ras0 (
        .clk         (clk),
        .rst         (rst),
        .push_i      (ras_push),
        .push_addr_i (id_push_addr_i),
        .pop_i       (ras_pop),
        .nonempty_o  (ras_nonempty),
        .top_o       (ras_top)
    );

    assign pc_plus4 = if_pc_i + 32'd4;

    always_comb begin
        branch_o     = 1'b0;
        pred_taken_o = 1'b0;
        pred_pc_o    = pc_plus4;
        if (if_is_ret) begin  // ret is a jalr, check it first
            branch_o = 1'b1;
            if (ras_nonempty) begin
                pred_taken_o = 1'b1;
                pred_pc_o    = ras_top;
            end
        end else if (if_is_jal) begin
            branch_o     = 1'b1;
            pred_taken_o = 1'b1;
            pred_pc_o    = btb_hit ? btb_target : if_pc_i + if_j_off;
        end else if (if_is_branch) begin
            branch_o     = 1'b1;
            pred_taken_o = bim_taken;
            if (bim_taken) begin
                pred_pc_o = btb_hit ? btb_target : if_pc_i + if_b_off;
            end
        end else if (if_is_jalr) begin
            // indirect, no target without the buffer
            branch_o     = 1'b1;
            pred_taken_o = bim_taken;
            if (bim_taken) begin
                pred_pc_o = btb_hit ? btb_target : pc_plus4;
            end
        end
    end

endmodule

`default_nettype wire

/* sim/bpu_asserts.sv */
`timescale 1ns/10ps
`default_nettype none

module bpu_asserts import bpu_pkg::*; (
    input logic                 clk,
    input logic                 rst,
    input logic [xlen-1:0]      if_pc_i,
    input logic                 branch_i,
    input logic                 pred_taken_i,
    input logic [xlen-1:0]      pred_pc_i,
    input logic [ras_ptr_w-1:0] ras_ptr_i
);

    int fail_cnt = 0;

    a_taken_branch: assert property (@(posedge clk) disable iff (rst)
        pred_taken_i |-> branch_i)
        else begin
            $error("taken prediction on a word that is not control flow");
            fail_cnt++;
        end

    // fall through is always the next word
    a_nt_next_pc: assert property (@(posedge clk) disable iff (rst)
        !pred_taken_i |-> (pred_pc_i == if_pc_i + 32'd4))
        else begin
            $error("not-taken prediction does not point to pc+4");
            fail_cnt++;
        end

    a_ptr_range: assert property (@(posedge clk) disable iff (rst)
        ras_ptr_i <= ras_ptr_w'(ras_depth))   // 64 means full
        else begin
            $error("return stack pointer beyond depth");
            fail_cnt++;
        end

endmodule

bind bpu_top bpu_asserts asrt0 (
    .clk          (clk),
    .rst          (rst),
    .if_pc_i      (if_pc_i),
    .branch_i     (branch_o),
    .pred_taken_i (pred_taken_o),
    .pred_pc_i    (pred_pc_o),
    .ras_ptr_i    (ras0.ptr_q)
);

`default_nettype wire

/* sim/bpu_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module bpu_tb;

    localparam int clk_half   = 4;    // 8 ns period
    localparam int rst_cycles = 8;
    localparam int max_cases  = 256;

    logic        clk;
    logic        rst;
    logic [31:0] if_pc;
    logic [31:0] if_inst;
    logic        id_push_valid;
    logic [31:0] id_push_addr;
    logic        id_stall;
    logic        ex_valid;
    logic        ex_taken;
    logic [31:0] ex_pc;
    logic [31:0] ex_inst;
    logic [31:0] ex_target;
    logic        ex_stall;
    logic        branch;
    logic        pred_taken;
    logic [31:0] pred_pc;

    // one entry per case line in file column order
    int          tst_a    [max_cases];
    logic [31:0] pc_a     [max_cases];
    logic [31:0] inst_a   [max_cases];
    logic [31:0] pv_a     [max_cases];
    logic [31:0] paddr_a  [max_cases];
    logic [31:0] ids_a    [max_cases];
    logic [31:0] exv_a    [max_cases];
    logic [31:0] ext_a    [max_cases];
    logic [31:0] expc_a   [max_cases];
    logic [31:0] exinst_a [max_cases];
    logic [31:0] extgt_a  [max_cases];
    logic [31:0] exs_a    [max_cases];
    logic [31:0] eb_a     [max_cases];
    logic [31:0] et_a     [max_cases];
    logic [31:0] epc_a    [max_cases];

    int   n_cases;
    logic load_ok;
    int   cur_test;
    int   cur_line;
    int   test_errs;
    int   test_cycles;
    int   total_errs;
    int   tests_ok;
    int   tests_bad;
    int   cycles;
    int   cycle_limit;

    bpu_top dut0 (
        .clk             (clk),
        .rst             (rst),
        .if_pc_i         (if_pc),
        .if_inst_i       (if_inst),
        .id_push_valid_i (id_push_valid),
        .id_push_addr_i  (id_push_addr),
        .id_stall_i      (id_stall),
        .ex_valid_i      (ex_valid),
        .ex_taken_i      (ex_taken),
        .ex_pc_i         (ex_pc),
        .ex_inst_i       (ex_inst),
        .ex_target_i     (ex_target),
        .ex_stall_i      (ex_stall),
        .branch_o        (branch),
        .pred_taken_o    (pred_taken),
        .pred_pc_o       (pred_pc)
    );

    always #(clk_half) clk = ~clk;

    task automatic check_val(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] t=%0t test %0d case %0d: %s is %h, expected %h",
                     $time, cur_test, cur_line, what, got, exp);
            test_errs++;
            total_errs++;
        end
    endtask

    task automatic load_cases;
        int    fd;
        int    cnt;
        int    bad;
        string line;
        bad     = 0;
        n_cases = 0;
        load_ok = 1'b0;
        fd      = $fopen("sim/bpu_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open sim/bpu_cases.txt");
        end else begin
            while (!$feof(fd) && n_cases < max_cases) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#") begin  // skip comments
                    cnt = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                  tst_a[n_cases], pc_a[n_cases], inst_a[n_cases],
                                  pv_a[n_cases], paddr_a[n_cases], ids_a[n_cases],
                                  exv_a[n_cases], ext_a[n_cases], expc_a[n_cases],
                                  exinst_a[n_cases], extgt_a[n_cases], exs_a[n_cases],
                                  eb_a[n_cases], et_a[n_cases], epc_a[n_cases]);
                    if (cnt == 15) begin
                        n_cases++;
                    end else begin
                        $display("case file line could not be read: %s", line);
                        bad++;
                    end
                end
            end
            $fclose(fd);
            load_ok = (n_cases > 0) && (bad == 0);
        end
    endtask

    task automatic drive_case(input int i);
        if_pc         <= pc_a[i];
        if_inst       <= inst_a[i];
        id_push_valid <= pv_a[i][0];
        id_push_addr  <= paddr_a[i];
        id_stall      <= ids_a[i][0];
        ex_valid      <= exv_a[i][0];
        ex_taken      <= ext_a[i][0];
        ex_pc         <= expc_a[i];
        ex_inst       <= exinst_a[i];
        ex_target     <= extgt_a[i];
        ex_stall      <= exs_a[i][0];
    endtask

    task automatic close_test;
        if (test_errs == 0) begin
            $display("test %0d ok, %0d cycles checked", cur_test, test_cycles);
            tests_ok++;
        end else begin
            $display("test %0d failed, %0d mismatches", cur_test, test_errs);
            tests_bad++;
        end
        test_errs   = 0;
        test_cycles = 0;
    endtask

    // guards against a stuck run
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        if_pc         = '0;
        if_inst       = '0;
        id_push_valid = 1'b0;
        id_push_addr  = '0;
        id_stall      = 1'b0;
        ex_valid      = 1'b0;
        ex_taken      = 1'b0;
        ex_pc         = '0;
        ex_inst       = '0;
        ex_target     = '0;
        ex_stall      = 1'b0;
        cycles        = 0;
        test_errs     = 0;
        test_cycles   = 0;
        total_errs    = 0;
        tests_ok      = 0;
        tests_bad     = 0;
        cycle_limit   = max_cases + rst_cycles + 20;
        load_cases();
        cycle_limit = n_cases + rst_cycles + 20;
        if (!load_ok) begin
            $display("no usable cases in sim/bpu_cases.txt");
            $display("TEST FAILED");
            $finish;
        end else begin
            repeat (rst_cycles) @(posedge clk);
            rst <= 1'b0;
            cur_test = tst_a[0];
            for (int i = 0; i < n_cases; i++) begin
                @(posedge clk);
                if (tst_a[i] != cur_test) begin
                    close_test();
                    cur_test = tst_a[i];
                end
                cur_line = i;
                drive_case(i);
                #(2 * clk_half - 1);  // just before the next edge
                check_val("branch_o", {31'd0, branch}, eb_a[i]);
                check_val("pred_taken_o", {31'd0, pred_taken}, et_a[i]);
                check_val("pred_pc_o", pred_pc, epc_a[i]);
                test_cycles++;
            end
            close_test();
            // assertions sample the last case on this edge
            @(posedge clk);
            #1;
            $display("summary: %0d tests passed, %0d tests failed, %0d mismatches, %0d %s",
                     tests_ok, tests_bad, total_errs, dut0.asrt0.fail_cnt,
                     "assertion failures");
            if (tests_bad == 0 && total_errs == 0 && dut0.asrt0.fail_cnt == 0) begin
                $display("TEST PASSED");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* sim/bpu_cases.txt */
# test if_pc if_inst push_v push_addr id_stall ex_valid ex_taken ex_pc ex_inst ex_target
# ex_stall exp_branch exp_taken exp_pc ; test in decimal, the rest hex, one line per cycle
# 1: cold tables, nothing predicts taken
1 00001000 00000013 0 00000000 0 0 0 00000000 00000000 00000000 0 0 0 00001004
1 00001004 00000863 0 00000000 0 0 0 00000000 00000000 00000000 0 1 0 00001008
1 00001008 00008067 0 00000000 0 0 0 00000000 00000000 00000000 0 1 0 0000100c
1 0000100c 00030067 0 00000000 0 0 0 00000000 00000000 00000000 0 1 0 00001010
# 2: jal with empty buffer uses the j offset
2 00002000 0080006f 0 00000000 0 0 0 00000000 00000000 00000000 0 1 1 00002008
2 00002010 ff9ff06f 0 00000000 0 0 0 00000000 00000000 00000000 0 1 1 00002008
2 00002020 100000ef 0 00000000 0 0 0 00000000 00000000 00000000 0 1 1 00002120
# 3: train beq at 3040 up then down, 3440 aliases the index with another tag
3 00003040 00000863 0 00000000 0 1 1 00003040 00000863 00003400 0 1 0 00003044
3 00003040 00000863 0 00000000 0 1 1 00003040 00000863 00003400 0 1 1 00003400
3 00003040 00000863 0 00000000 0 0 0 00000000 00000000 00000000 0 1 1 00003400
3 00003440 00000863 0 00000000 0 0 0 00000000 00000000 00000000 0 1 1 00003450
3 00003040 00000863 0 00000000 0 1 0 00003040 00000863 00000000 0 1 1 00003400
3 00003040 00000863 0 00000000 0 1 0 00003040 00000863 00000000 0 1 1 00003400
3 00003040 00000863 0 00000000 0 0 0 00000000 00000000 00000000 0 1 0 00003044
3 00003440 00000863 0 00000000 0 0 0 00000000 00000000 00000000 0 1 0 00003444
# 4: three calls, returns come back in reverse order
4 00004000 00000013 1 00004004 0 0 0 00000000 00000000 00000000 0 0 0 00004004
4 00004100 00008067 1 00004104 0 0 0 00000000 00000000 00000000 0 1 1 00004004
4 00004200 00000013 1 00004204 0 0 0 00000000 00000000 00000000 0 0 0 00004204
4 00004300 00008067 0 00000000 0 1 1 00004300 00008067 00004204 0 1 1 00004204
4 00004300 00028067 0 00000000 0 1 1 00004300 00008067 00004104 0 1 1 00004104
4 00004300 00008067 0 00000000 0 1 1 00004300 00028067 00004004 0 1 1 00004004
4 00004300 00008067 0 00000000 0 0 0 00000000 00000000 00000000 0 1 0 00004304
# 5: stalled pushes and pops leave the stack alone
5 00005000 00000013 1 00005004 0 0 0 00000000 00000000 00000000 0 0 0 00005004
5 00005100 00008067 1 00005104 1 0 0 00000000 00000000 00000000 0 1 1 00005004
5 00005100 00008067 1 00005204 0 0 0 00000000 00000000 00000000 1 1 1 00005004
5 00005100 00008067 0 00000000 0 1 1 00005100 00008067 00005004 1 1 1 00005004
5 00005100 00008067 0 00000000 0 0 0 00000000 00000000 00000000 0 1 1 00005004
5 00005100 00008067 0 00000000 0 1 1 00005100 00008067 00005004 0 1 1 00005004
5 00005100 00008067 0 00000000 0 0 0 00000000 00000000 00000000 0 1 0 00005104

/* vlog.f */
rtl/bpu_pkg.sv
rtl/inst_predecode.sv
rtl/bimodal_table.sv
rtl/branch_target_buffer.sv
rtl/return_addr_stack.sv
rtl/bpu_top.sv
sim/bpu_asserts.sv
sim/bpu_tb.sv

/* Bender.yml */
package:
  name: bpu

sources:
  - files:
      - rtl/bpu_pkg.sv
      - rtl/inst_predecode.sv
      - rtl/bimodal_table.sv
      - rtl/branch_target_buffer.sv
      - rtl/return_addr_stack.sv
      - rtl/bpu_top.sv

  - target: simulation
    files:
      - sim/bpu_asserts.sv
      - sim/bpu_tb.sv
